// File: hw/insn_consts.svh
`ifndef INSN_CONSTS_SVH
`define INSN_CONSTS_SVH

// Width of one RV32 instruction word.
`define INSN_WIDTH 32

// Number of instruction buffer entries.
// Must be a power of two so that the pointers wrap on their own.
`define INSN_BUFFER_DEPTH 8

// Entry and credit counters must be able to hold the full depth.
`define INSN_COUNT_WIDTH 4

`endif

// File: hw/insn_pkg.sv
package insn_pkg;

    // Opcode of the I-type arithmetic group (addi, slti, xori and so on).
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;

    // Register-register layout.
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    // Register-immediate layout.
    // The 12-bit immediate overlays funct7 and rs2 of the R layout.
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    // One instruction word seen through either layout.
    // The opcode, rd, rs1 and funct3 fields sit at the same bits in both views,
    // so decode can take them from whichever view is convenient.
    typedef union packed {
        r_type_t r_view;
        i_type_t i_view;
    } insn_word_u;

endpackage

// File: hw/insn_buffer_if.sv
`timescale 1ns/1ns

// Links the fetch stage, the instruction buffer and the decode stage.
// Fetch writes up to two entries per cycle, decode pops at most one, and
// every pop hands one credit back to fetch in the same cycle.
interface insn_buffer_if;

    // Write side, driven by fetch.
    // write_high is only valid together with write_low.
    logic                 write_low;
    logic                 write_high;
    insn_pkg::insn_word_u write_word_low;
    insn_pkg::insn_word_u write_word_high;

    // One credit per popped entry.
    logic                 credit_return;

    // Read side.
    logic                 read_valid;
    insn_pkg::insn_word_u read_word;
    logic                 pop;

    modport fetch (
        output write_low,
        output write_high,
        output write_word_low,
        output write_word_high,
        input  credit_return
    );

    modport buffer (
        input  write_low,
        input  write_high,
        input  write_word_low,
        input  write_word_high,
        input  pop,
        output credit_return,
        output read_valid,
        output read_word
    );

    modport decode (
        input  read_valid,
        input  read_word,
        output pop
    );

endinterface

// File: hw/fetch_stage.sv
`timescale 1ns/1ns
`include "insn_consts.svh"

module fetch_stage (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 flush,
    input  logic                 fetch_valid_low,
    input  logic                 fetch_valid_high,
    input  insn_pkg::insn_word_u fetch_word_low,
    input  insn_pkg::insn_word_u fetch_word_high,
    output logic                 fetch_ready,
    insn_buffer_if.fetch         wr
);

    // Credits track free buffer entries. The pending pair is charged
    // on the edge where it is written.
    logic [`INSN_COUNT_WIDTH-1:0] credits;
    logic [`INSN_COUNT_WIDTH-1:0] pending_count;
    logic [`INSN_COUNT_WIDTH-1:0] returned;

    logic                 pending_valid_low;
    logic                 pending_valid_high;
    insn_pkg::insn_word_u pending_word_low;
    insn_pkg::insn_word_u pending_word_high;

    logic accept;

    always_comb begin
        pending_count = `INSN_COUNT_WIDTH'(pending_valid_low)
                      + `INSN_COUNT_WIDTH'(pending_valid_high);
        returned      = `INSN_COUNT_WIDTH'(wr.credit_return);
    end

    // A new pair may need two entries on top of whatever is still pending.
    assign fetch_ready = credits >= pending_count + `INSN_COUNT_WIDTH'(2);
    assign accept      = fetch_ready && fetch_valid_low;

    // The pending pair goes straight into the buffer.
    assign wr.write_low       = pending_valid_low;
    assign wr.write_high      = pending_valid_high;
    assign wr.write_word_low  = pending_word_low;
    assign wr.write_word_high = pending_word_high;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            credits            <= `INSN_COUNT_WIDTH'(`INSN_BUFFER_DEPTH);
            pending_valid_low  <= 1'b0;
            pending_valid_high <= 1'b0;
        end else if (flush) begin
            // The buffer empties on this edge as well, so all credits come back.
            credits            <= `INSN_COUNT_WIDTH'(`INSN_BUFFER_DEPTH);
            pending_valid_low  <= 1'b0;
            pending_valid_high <= 1'b0;
        end else begin
            credits            <= credits - pending_count + returned;
            pending_valid_low  <= accept;
            pending_valid_high <= accept && fetch_valid_high;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pending_word_low  <= fetch_word_low;
            pending_word_high <= fetch_word_high;
        end
    end

endmodule

// File: hw/insn_buffer.sv
`timescale 1ns/1ns
`include "insn_consts.svh"

module insn_buffer (
    input  logic          clk,
    input  logic          arst_n,
    input  logic          flush,
    insn_buffer_if.buffer bus
);

    localparam int IDX_W = $clog2(`INSN_BUFFER_DEPTH);

    // Source of each entry's next value.
    localparam logic [1:0] SRC_KEEP = 2'd0;
    localparam logic [1:0] SRC_LOW  = 2'd1;
    localparam logic [1:0] SRC_HIGH = 2'd2;

    insn_pkg::insn_word_u entries      [`INSN_BUFFER_DEPTH];
    insn_pkg::insn_word_u next_entries [`INSN_BUFFER_DEPTH];
    logic [1:0]           src_sel      [`INSN_BUFFER_DEPTH];

    logic [IDX_W-1:0] head;
    logic [IDX_W-1:0] tail;
    logic [IDX_W-1:0] tail_plus_one;

    logic [`INSN_COUNT_WIDTH-1:0] count;
    logic [`INSN_COUNT_WIDTH-1:0] write_count;
    logic [`INSN_COUNT_WIDTH-1:0] read_count;

    always_comb begin
        write_count   = `INSN_COUNT_WIDTH'(bus.write_low)
                      + `INSN_COUNT_WIDTH'(bus.write_high);
        read_count    = `INSN_COUNT_WIDTH'(bus.pop);
        tail_plus_one = tail + IDX_W'(1);
    end

    // The low word lands at the tail and the high word right behind it.
    // A high write never comes alone, so no other placement is needed.
    always_comb begin
        for (int i = 0; i < `INSN_BUFFER_DEPTH; i++) begin
            if (bus.write_low && IDX_W'(i) == tail) begin
                src_sel[i] = SRC_LOW;
            end else if (bus.write_high && IDX_W'(i) == tail_plus_one) begin
                src_sel[i] = SRC_HIGH;
            end else begin
                src_sel[i] = SRC_KEEP;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `INSN_BUFFER_DEPTH; i++) begin
            case (src_sel[i])
                SRC_LOW:  next_entries[i] = bus.write_word_low;
                SRC_HIGH: next_entries[i] = bus.write_word_high;
                default:  next_entries[i] = entries[i];
            endcase
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `INSN_BUFFER_DEPTH; i++) begin
            entries[i] <= next_entries[i];
        end
    end

    // Stale entries may remain after a flush; the count alone says what is readable.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            head  <= head + IDX_W'(read_count);
            tail  <= tail + IDX_W'(write_count);
            count <= count + write_count - read_count;
        end
    end

    assign bus.read_word     = entries[head];
    assign bus.read_valid    = count != '0;
    // Each pop frees exactly one entry.
    assign bus.credit_return = bus.pop;

endmodule

// File: hw/decode_stage.sv
`timescale 1ns/1ns

module decode_stage (
    input  logic          clk,
    input  logic          arst_n,
    input  logic          flush,
    input  logic          decode_ready,
    insn_buffer_if.decode rd_port,
    output logic          decode_valid,
    output logic          decode_is_imm,
    output logic [6:0]    decode_opcode,
    output logic [4:0]    decode_rd,
    output logic [4:0]    decode_rs1,
    output logic [4:0]    decode_rs2,
    output logic [11:0]   decode_imm
);

    insn_pkg::insn_word_u word;
    logic                 pop;

    assign word = rd_port.read_word;

    // Take a new word when the output register is empty or being drained.
    assign pop         = rd_port.read_valid && (!decode_valid || decode_ready);
    assign rd_port.pop = pop;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            decode_valid <= 1'b0;
        end else if (flush) begin
            decode_valid <= 1'b0;
        end else if (pop) begin
            decode_valid <= 1'b1;
        end else if (decode_ready) begin
            decode_valid <= 1'b0;
        end
    end

    // Both views are read from the same word. rs2 only exists in the R layout
    // and the immediate only in the I layout, while the shared fields are
    // taken from whichever view is at hand.
    always_ff @(posedge clk) begin
        if (pop) begin
            decode_opcode <= word.r_view.opcode;
            decode_rd     <= word.i_view.rd;
            decode_rs1    <= word.r_view.rs1;
            decode_rs2    <= word.r_view.rs2;
            decode_imm    <= word.i_view.imm;
            decode_is_imm <= word.r_view.opcode == insn_pkg::OPCODE_OP_IMM;
        end
    end

endmodule

// File: hw/frontend_top.sv
`timescale 1ns/1ns
`include "insn_consts.svh"

module frontend_top (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   flush,

    // Fetch side: one pair per accepted cycle, the high word is optional.
    input  logic                   fetch_valid_low,
    input  logic [`INSN_WIDTH-1:0] fetch_word_low,
    input  logic                   fetch_valid_high,
    input  logic [`INSN_WIDTH-1:0] fetch_word_high,
    output logic                   fetch_ready,

    // Decode side.
    input  logic                   decode_ready,
    output logic                   decode_valid,
    output logic [6:0]             decode_opcode,
    output logic [4:0]             decode_rd,
    output logic [4:0]             decode_rs1,
    output logic [4:0]             decode_rs2,
    output logic [11:0]            decode_imm,
    output logic                   decode_is_imm
);

    insn_buffer_if buffer_bus ();

    fetch_stage i_fetch (
        .clk              (clk),
        .arst_n           (arst_n),
        .flush            (flush),
        .fetch_valid_low  (fetch_valid_low),
        .fetch_valid_high (fetch_valid_high),
        .fetch_word_low   (fetch_word_low),
        .fetch_word_high  (fetch_word_high),
        .fetch_ready      (fetch_ready),
        .wr               (buffer_bus.fetch)
    );

    insn_buffer i_buffer (
        .clk    (clk),
        .arst_n (arst_n),
        .flush  (flush),
        .bus    (buffer_bus.buffer)
    );

    decode_stage i_decode (
        .clk           (clk),
        .arst_n        (arst_n),
        .flush         (flush),
        .decode_ready  (decode_ready),
        .rd_port       (buffer_bus.decode),
        .decode_valid  (decode_valid),
        .decode_is_imm (decode_is_imm),
        .decode_opcode (decode_opcode),
        .decode_rd     (decode_rd),
        .decode_rs1    (decode_rs1),
        .decode_rs2    (decode_rs2),
        .decode_imm    (decode_imm)
    );

endmodule

// File: verif/tb_clock.sv
`timescale 1ns/1ns

// Free-running clock for the testbench.
module tb_clock #(
    parameter int PERIOD_NS = 20
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2);
            clk = ~clk;
        end
    end

endmodule

// File: verif/frontend_sva.sv
`timescale 1ns/1ns
`include "insn_consts.svh"

module frontend_sva (
    input logic                         clk,
    input logic                         arst_n,
    input logic [`INSN_COUNT_WIDTH-1:0] count,
    input logic                         pop,
    input logic                         read_valid,
    input logic                         write_low,
    input logic                         write_high
);

    // Credits must keep the buffer from ever holding more than its depth.
    count_in_range: assert property (@(posedge clk) disable iff (!arst_n)
        count <= `INSN_COUNT_WIDTH'(`INSN_BUFFER_DEPTH))
        else $error("buffer count exceeds depth");

    pop_needs_valid: assert property (@(posedge clk) disable iff (!arst_n)
        pop |-> read_valid)
        else $error("pop while buffer is empty");

    // The high word is only ever the second half of a pair.
    high_needs_low: assert property (@(posedge clk) disable iff (!arst_n)
        write_high |-> write_low)
        else $error("high write without low write");

endmodule

bind insn_buffer frontend_sva i_frontend_sva (
    .clk        (clk),
    .arst_n     (arst_n),
    .count      (count),
    .pop        (bus.pop),
    .read_valid (bus.read_valid),
    .write_low  (bus.write_low),
    .write_high (bus.write_high)
);

// File: verif/tb_frontend.sv
`timescale 1ns/1ns
`include "insn_consts.svh"

module tb_frontend;

    typedef struct packed {
        logic [31:0] word;
        logic [6:0]  opcode;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        logic        is_imm;
        logic        pair;
    } stim_row_t;

    localparam int TABLE_LEN   = 12;
    localparam int CYCLE_LIMIT = TABLE_LEN * 8 + 200;

    // Each row holds a word, its expected opcode, rd, rs1, rs2, imm and is_imm,
    // and whether it is sent as a pair with the next row.
    // R-type words are built as funct7/rs2/rs1/funct3/rd/opcode.
    // I-type words are built as imm/rs1/funct3/rd/opcode.
    localparam stim_row_t TABLE_ROWS [TABLE_LEN] = '{
    '{{7'h00,5'd3,5'd2,3'd0,5'd1,7'h33}, 7'h33, 5'd1, 5'd2, 5'd3, 12'h003, 1'b0, 1'b1},
    '{{12'hfff,5'd6,3'd0,5'd5,7'h13}, 7'h13, 5'd5, 5'd6, 5'd31, 12'hfff, 1'b1, 1'b0},
    '{{7'h20,5'd9,5'd8,3'd0,5'd7,7'h33}, 7'h33, 5'd7, 5'd8, 5'd9, 12'h409, 1'b0, 1'b1},
    '{{12'h0f0,5'd11,3'd4,5'd10,7'h13}, 7'h13, 5'd10, 5'd11, 5'd16, 12'h0f0, 1'b1, 1'b1},
    '{{12'h7ff,5'd13,3'd2,5'd12,7'h03}, 7'h03, 5'd12, 5'd13, 5'd31, 12'h7ff, 1'b0, 1'b0},
    '{{7'h00,5'd29,5'd30,3'd7,5'd31,7'h33}, 7'h33, 5'd31, 5'd30, 5'd29, 12'h01d, 1'b0, 1'b1},
    '{{12'h800,5'd1,3'd2,5'd0,7'h13}, 7'h13, 5'd0, 5'd1, 5'd0, 12'h800, 1'b1, 1'b1},
    '{{12'h124,5'd2,3'd0,5'd1,7'h67}, 7'h67, 5'd1, 5'd2, 5'd4, 12'h124, 1'b0, 1'b0},
    '{{7'h20,5'd16,5'd15,3'd5,5'd14,7'h33}, 7'h33, 5'd14, 5'd15, 5'd16, 12'h410, 1'b0, 1'b1},
    '{{12'h555,5'd18,3'd6,5'd17,7'h13}, 7'h13, 5'd17, 5'd18, 5'd21, 12'h555, 1'b1, 1'b1},
    '{{7'h01,5'd21,5'd20,3'd0,5'd19,7'h33}, 7'h33, 5'd19, 5'd20, 5'd21, 12'h035, 1'b0, 1'b0},
    '{{12'h407,5'd23,3'd5,5'd22,7'h13}, 7'h13, 5'd22, 5'd23, 5'd7, 12'h407, 1'b1, 1'b0}
    };

    logic        clk;
    logic        arst_n;
    logic        flush;
    logic        fetch_valid_low;
    logic [31:0] fetch_word_low;
    logic        fetch_valid_high;
    logic [31:0] fetch_word_high;
    logic        fetch_ready;
    logic        decode_ready;
    logic        decode_valid;
    logic [6:0]  decode_opcode;
    logic [4:0]  decode_rd;
    logic [4:0]  decode_rs1;
    logic [4:0]  decode_rs2;
    logic [11:0] decode_imm;
    logic        decode_is_imm;

    // Table rows of the words on the fetch inputs, and of every accepted word in order.
    int          low_idx;
    int          high_idx;
    int          scoreboard [$];
    int          decoded_count;
    int          error_count;
    int          check_count;
    int          test_count;
    int          failing_tests;
    int          cycle_count;
    logic        ready_random;
    logic [31:0] lcg_state;

    tb_clock #(.PERIOD_NS(20)) i_clock (.clk(clk));

    frontend_top i_frontend_top (
        .clk              (clk),
        .arst_n           (arst_n),
        .flush            (flush),
        .fetch_valid_low  (fetch_valid_low),
        .fetch_word_low   (fetch_word_low),
        .fetch_valid_high (fetch_valid_high),
        .fetch_word_high  (fetch_word_high),
        .fetch_ready      (fetch_ready),
        .decode_ready     (decode_ready),
        .decode_valid     (decode_valid),
        .decode_opcode    (decode_opcode),
        .decode_rd        (decode_rd),
        .decode_rs1       (decode_rs1),
        .decode_rs2       (decode_rs2),
        .decode_imm       (decode_imm),
        .decode_is_imm    (decode_is_imm)
    );

    function automatic logic next_random_bit();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[16];
    endfunction

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("error at %0t ns: %s expected 0x%0h, got 0x%0h",
                     $time, name, expected, actual);
        end
    endtask

    // Inputs change 2 ns after the rising edge.
    task automatic step_cycle();
        @(posedge clk);
        #2;
        if (ready_random) begin
            decode_ready = next_random_bit();
        end
    endtask

    // Holds the words on the fetch port until the edge that accepts them.
    task automatic send_words(input int low_row, input int high_row);
        logic was_ready;
        fetch_valid_low  = 1'b1;
        fetch_word_low   = TABLE_ROWS[low_row].word;
        low_idx          = low_row;
        fetch_valid_high = high_row >= 0;
        fetch_word_high  = high_row >= 0 ? TABLE_ROWS[high_row].word : 32'h0;
        high_idx         = high_row;
        do begin
            was_ready = fetch_ready;
            step_cycle();
        end while (!was_ready);
        fetch_valid_low  = 1'b0;
        fetch_valid_high = 1'b0;
    endtask

    task automatic apply_table();
        int row;
        row = 0;
        while (row < TABLE_LEN) begin
            if (TABLE_ROWS[row].pair && row + 1 < TABLE_LEN) begin
                send_words(row, row + 1);
                row += 2;
            end else begin
                send_words(row, -1);
                row += 1;
            end
        end
    endtask

    task automatic drain_output();
        ready_random = 1'b0;
        decode_ready = 1'b1;
        while (scoreboard.size() != 0 || decode_valid) begin
            step_cycle();
        end
    endtask

    task automatic finish_test(input string name, input int start_errors);
        test_count++;
        if (error_count == start_errors) begin
            $display("test %0d %s: ok", test_count, name);
        end else begin
            failing_tests++;
            $display("test %0d %s: %0d errors", test_count, name, error_count - start_errors);
        end
    endtask

    task automatic reset_values();
        int start_errors;
        start_errors = error_count;
        compare_value("fetch_ready", 32'd1, 32'(fetch_ready));
        compare_value("decode_valid", 32'd0, 32'(decode_valid));
        finish_test("reset_values", start_errors);
    endtask

    task automatic pass_through();
        int start_errors;
        int start_decoded;
        start_errors  = error_count;
        start_decoded = decoded_count;
        decode_ready  = 1'b1;
        apply_table();
        drain_output();
        compare_value("decoded_words", TABLE_LEN, decoded_count - start_decoded);
        finish_test("pass_through", start_errors);
    endtask

    task automatic single_latency();
        int start_errors;
        int latency;
        start_errors = error_count;
        decode_ready = 1'b1;
        compare_value("decode_valid", 32'd0, 32'(decode_valid));
        compare_value("fetch_ready", 32'd1, 32'(fetch_ready));
        send_words(4, -1);
        // Now just after the acceptance edge.
        latency = 0;
        while (!decode_valid && latency < 10) begin
            step_cycle();
            latency++;
        end
        compare_value("decode_latency", 32'd2, latency);
        drain_output();
        finish_test("single_latency", start_errors);
    endtask

    task automatic fill_under_stall();
        int start_errors;
        int start_decoded;
        int accepted;
        int stalled;
        int row;
        start_errors     = error_count;
        start_decoded    = decoded_count;
        decode_ready     = 1'b0;
        accepted         = 0;
        stalled          = 0;
        row              = 0;
        fetch_valid_low  = 1'b1;
        fetch_valid_high = 1'b1;
        while (stalled < 6 && accepted <= 2 * `INSN_BUFFER_DEPTH) begin
            low_idx         = row % TABLE_LEN;
            high_idx        = (row + 1) % TABLE_LEN;
            fetch_word_low  = TABLE_ROWS[low_idx].word;
            fetch_word_high = TABLE_ROWS[high_idx].word;
            if (fetch_ready) begin
                accepted += 2;
                row      += 2;
            end else begin
                stalled++;
            end
            step_cycle();
        end
        fetch_valid_low  = 1'b0;
        fetch_valid_high = 1'b0;
        compare_value("accepted_words", `INSN_BUFFER_DEPTH, accepted);
        compare_value("fetch_ready", 32'd0, 32'(fetch_ready));
        compare_value("decode_valid", 32'd1, 32'(decode_valid));
        drain_output();
        compare_value("decoded_words", accepted, decoded_count - start_decoded);
        finish_test("fill_under_stall", start_errors);
    endtask

    task automatic random_ready_stress();
        int start_errors;
        int start_decoded;
        start_errors  = error_count;
        start_decoded = decoded_count;
        ready_random  = 1'b1;
        repeat (3) begin
            apply_table();
        end
        drain_output();
        compare_value("decoded_words", 3 * TABLE_LEN, decoded_count - start_decoded);
        finish_test("random_ready_stress", start_errors);
    endtask

    task automatic flush_recovery();
        int start_errors;
        int start_decoded;
        start_errors = error_count;
        decode_ready = 1'b0;
        send_words(0, 1);
        send_words(2, 3);
        send_words(5, 6);
        // The last pair is still in the fetch register when the flush hits.
        flush = 1'b1;
        step_cycle();
        flush = 1'b0;
        compare_value("decode_valid", 32'd0, 32'(decode_valid));
        compare_value("fetch_ready", 32'd1, 32'(fetch_ready));
        decode_ready = 1'b1;
        repeat (4) begin
            step_cycle();
            compare_value("decode_valid", 32'd0, 32'(decode_valid));
        end
        start_decoded = decoded_count;
        apply_table();
        drain_output();
        compare_value("decoded_words", TABLE_LEN, decoded_count - start_decoded);
        finish_test("flush_recovery", start_errors);
    endtask

    // Records accepted words and checks every word that leaves decode.
    initial begin
        stim_row_t row;
        forever begin
            @(posedge clk);
            if (arst_n && flush) begin
                scoreboard.delete();
            end else if (arst_n) begin
                if (fetch_ready && fetch_valid_low) begin
                    scoreboard.push_back(low_idx);
                    if (fetch_valid_high) begin
                        scoreboard.push_back(high_idx);
                    end
                end
                if (decode_valid && decode_ready) begin
                    if (scoreboard.size() == 0) begin
                        error_count++;
                        $display("decode produced a word at %0t ns that was never accepted",
                                 $time);
                    end else begin
                        row = TABLE_ROWS[scoreboard.pop_front()];
                        decoded_count++;
                        compare_value("decode_opcode", 32'(row.opcode), 32'(decode_opcode));
                        compare_value("decode_rd", 32'(row.rd), 32'(decode_rd));
                        compare_value("decode_rs1", 32'(row.rs1), 32'(decode_rs1));
                        compare_value("decode_rs2", 32'(row.rs2), 32'(decode_rs2));
                        compare_value("decode_imm", 32'(row.imm), 32'(decode_imm));
                        compare_value("decode_is_imm", 32'(row.is_imm), 32'(decode_is_imm));
                    end
                end
            end
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        arst_n           = 1'b0;
        flush            = 1'b0;
        fetch_valid_low  = 1'b0;
        fetch_word_low   = 32'h0;
        fetch_valid_high = 1'b0;
        fetch_word_high  = 32'h0;
        decode_ready     = 1'b0;
        low_idx          = 0;
        high_idx         = -1;
        decoded_count    = 0;
        error_count      = 0;
        check_count      = 0;
        test_count       = 0;
        failing_tests    = 0;
        ready_random     = 1'b0;
        lcg_state        = 32'd19;
        repeat (10) begin
            @(posedge clk);
        end
        #2;
        arst_n = 1'b1;

        reset_values();
        pass_through();
        single_latency();
        fill_under_stall();
        random_ready_stress();
        flush_recovery();

        $display("summary: %0d tests, %0d with errors, %0d checks, %0d errors",
                 test_count, failing_tests, check_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+hw
hw/insn_pkg.sv
hw/insn_buffer_if.sv
hw/fetch_stage.sv
hw/insn_buffer.sv
hw/decode_stage.sv
hw/frontend_top.sv
verif/tb_clock.sv
verif/frontend_sva.sv
verif/tb_frontend.sv

// File: Makefile
TOP := tb_frontend

.PHONY: all run lint clean

all: run

obj_dir/Vtb_frontend: files.f $(wildcard hw/*.sv hw/*.svh verif/*.sv)
	verilator --binary --timing --assert -f files.f --top-module $(TOP)

run: obj_dir/Vtb_frontend
	@out="$$(./obj_dir/Vtb_frontend)"; echo "$$out"; \
	echo "$$out" | grep -qx "All tests passed"

lint:
	verilator --lint-only --timing --assert -f files.f --top-module $(TOP)
	verilator --lint-only -Ihw hw/insn_pkg.sv hw/insn_buffer_if.sv hw/fetch_stage.sv \
		hw/insn_buffer.sv hw/decode_stage.sv hw/frontend_top.sv --top-module frontend_top

clean:
	rm -rf obj_dir
